// File: include/bexlite_settings.svh
`ifndef BEXLITE_SETTINGS_SVH
`define BEXLITE_SETTINGS_SVH

// reset fetch address
`define START_ADDR 32'h00000000

// requests per bus burst
`define REQ_MAX 4

// fifo depth is 2**FIFO_AWIDTH words
`define FIFO_AWIDTH 4

`define NUM_REGS 16

`endif

// File: hw/bexlite_isa_pkg.sv
`default_nettype none

package bexlite_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    ADDI,    // 15-bit unsigned imm
    LDI,     // long form
    JMP,     // long form, absolute
    HALT
  } opcode_t;

  // field positions in the first instruction word
  localparam int LONG_BIT = 0;
  localparam int OP_LSB   = 1;
  localparam int OP_MSB   = 4;
  localparam int RD_LSB   = 5;
  localparam int RD_MSB   = 8;
  localparam int RA_LSB   = 9;
  localparam int RA_MSB   = 12;
  localparam int RB_LSB   = 13;
  localparam int RB_MSB   = 16;
  localparam int IMM_LSB  = 17;
  localparam int IMM_MSB  = 31;

endpackage

`default_nettype wire

// File: hw/bexlite_fetch_pkg.sv
`default_nettype none

package bexlite_fetch_pkg;

  typedef logic [31:0] addr_t;   // byte address

  typedef enum logic [1:0] {
    SB_IDLE,
    SB_FETCH,
    SB_END,
    SB_HALT
  } bus_state_t;

  typedef enum logic [1:0] {
    S_RESET,
    S_FETCH,
    S_FETCH2   // waiting on second half
  } fetch_state_t;

endpackage

`default_nettype wire

// File: hw/fetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "bexlite_settings.svh"

module fetch_fifo #(
  parameter int AWIDTH = `FIFO_AWIDTH
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   clr_i,
  input  logic                   push_i,
  input  bexlite_isa_pkg::word_t din_i,
  input  logic                   pop_i,
  output bexlite_isa_pkg::word_t dout_o,
  output logic                   empty_o,
  output logic                   full_o
);
  import bexlite_isa_pkg::*;

  localparam int DEPTH = 1 << AWIDTH;

  word_t             mem [DEPTH];
  logic [AWIDTH-1:0] rd_ptr;
  logic [AWIDTH-1:0] wr_ptr;
  logic [AWIDTH:0]   count;
  logic              do_push;
  logic              do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count == '0);
  assign full_o  = (count == (AWIDTH+1)'(DEPTH));
  assign dout_o  = mem[rd_ptr];   // head word

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else if (clr_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AWIDTH+1)'(do_push) - (AWIDTH+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push && !clr_i)
      mem[wr_ptr] <= din_i;
  end

endmodule

`default_nettype wire

// File: hw/ifetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "bexlite_settings.svh"

module ifetch (
  input  logic                     clk_i,
  input  logic                     rst_i,
  output logic                     bus_cyc_o,
  output logic                     bus_stb_o,
  output bexlite_fetch_pkg::addr_t bus_adr_o,
  input  logic                     bus_stall_i,
  input  logic                     bus_ack_i,
  input  bexlite_isa_pkg::word_t   bus_dat_i,
  output logic [63:0]              ir_o,
  input  logic                     pc_set_i,
  input  bexlite_fetch_pkg::addr_t pc_target_i,
  input  logic                     halt_i
);
  import bexlite_isa_pkg::*;
  import bexlite_fetch_pkg::*;

  localparam int CW = $clog2(`REQ_MAX + 1);

  bus_state_t   bus_state, bus_state_next;
  fetch_state_t state, state_next;
  addr_t        bus_adr_next;
  logic [CW-1:0] req_count, req_count_next;
  logic [CW-1:0] ack_count, ack_count_next;
  logic         drop, drop_next;   // discard acks from an abandoned path
  logic [63:0]  ir_next;
  word_t        low, low_next;
  word_t        head;
  logic         empty, full;
  logic         pop;

  assign bus_cyc_o = (bus_state == SB_FETCH) || (bus_state == SB_END);
  assign bus_stb_o = (bus_state == SB_FETCH);

  assign pop = !empty && !halt_i && !pc_set_i && (state != S_RESET);

  fetch_fifo #(.AWIDTH(`FIFO_AWIDTH)) fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clr_i   (pc_set_i),
    .push_i  (bus_ack_i && !drop),
    .din_i   (bus_dat_i),
    .pop_i   (pop),
    .dout_o  (head),
    .empty_o (empty),
    .full_o  (full)
  );

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      bus_state <= SB_IDLE;
      state     <= S_RESET;
      bus_adr_o <= `START_ADDR;
      req_count <= '0;
      ack_count <= '0;
      drop      <= 1'b0;
      ir_o      <= '0;
    end
    else
    begin
      bus_state <= bus_state_next;
      state     <= state_next;
      bus_adr_o <= bus_adr_next;
      req_count <= req_count_next;
      ack_count <= ack_count_next;
      drop      <= drop_next;
      ir_o      <= ir_next;
    end
  end

  always_ff @(posedge clk_i)
  begin
    low <= low_next;   // first half of a long insn
  end

  // bus requester
  always_comb
  begin
    bus_state_next = bus_state;
    bus_adr_next   = bus_adr_o;
    req_count_next = req_count;
    ack_count_next = ack_count;
    drop_next      = drop;
    case (bus_state)
      SB_IDLE:
      begin
        req_count_next = '0;
        ack_count_next = '0;
        drop_next      = 1'b0;
        if (halt_i)
          bus_state_next = SB_HALT;
        else if (!full && !pc_set_i)
          bus_state_next = SB_FETCH;
        if (pc_set_i)
          bus_adr_next = pc_target_i;
      end
      SB_FETCH:
      begin
        if (bus_ack_i)
          ack_count_next = ack_count + 1'b1;
        if (!bus_stall_i)
        begin
          bus_adr_next   = bus_adr_o + 32'h4;
          req_count_next = req_count + 1'b1;
          if (req_count == CW'(`REQ_MAX - 1))
            bus_state_next = SB_END;
        end
        if (halt_i)
          bus_state_next = SB_END;   // stop requesting, drain
        if (pc_set_i)
        begin
          bus_adr_next   = pc_target_i;
          drop_next      = 1'b1;
          bus_state_next = SB_END;
        end
      end
      SB_END:
      begin
        if (bus_ack_i)
          ack_count_next = ack_count + 1'b1;
        if (req_count == ack_count)
          bus_state_next = halt_i ? SB_HALT : SB_IDLE;
        if (pc_set_i)
        begin
          bus_adr_next = pc_target_i;
          drop_next    = 1'b1;
        end
      end
      default:
        bus_state_next = SB_HALT;   // parked for good
    endcase
  end

  // instruction assembly
  always_comb
  begin
    state_next = state;
    ir_next    = '0;
    low_next   = low;
    case (state)
      S_RESET:
        state_next = S_FETCH;
      S_FETCH:
      begin
        if (pop)
        begin
          if (head[LONG_BIT])
          begin
            low_next   = head;
            state_next = S_FETCH2;
          end
          else
            ir_next = {32'h0, head};
        end
      end
      S_FETCH2:
      begin
        if (pop)
        begin
          ir_next    = {head, low};
          state_next = S_FETCH;
        end
      end
      default:
        state_next = S_RESET;
    endcase
    if (pc_set_i)
      state_next = S_RESET;
  end

endmodule

`default_nettype wire

// File: hw/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [63:0]                ir_i,
  input  logic                       flush_i,
  output logic                       ins_valid_o,
  output bexlite_isa_pkg::opcode_t   opcode_o,
  output bexlite_isa_pkg::reg_idx_t  rd_o,
  output bexlite_isa_pkg::reg_idx_t  ra_o,
  output bexlite_isa_pkg::reg_idx_t  rb_o,
  output bexlite_isa_pkg::word_t     imm_o
);
  import bexlite_isa_pkg::*;

  logic [63:0] ir;
  word_t       imm;

  assign ir = flush_i ? 64'h0 : ir_i;   // flush loads a bubble

  always_comb
  begin
    if (ir[LONG_BIT])
      imm = ir[63:32];
    else
      imm = {17'h0, ir[IMM_MSB:IMM_LSB]};
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ins_valid_o <= 1'b0;
      opcode_o    <= NOP;
    end
    else
    begin
      ins_valid_o <= |ir;
      opcode_o    <= opcode_t'(ir[OP_MSB:OP_LSB]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_o  <= ir[RD_MSB:RD_LSB];
    ra_o  <= ir[RA_MSB:RA_LSB];
    rb_o  <= ir[RB_MSB:RB_LSB];
    imm_o <= imm;
  end

endmodule

`default_nettype wire

// File: hw/insn_execute.sv
`timescale 1ns/1ps
`default_nettype none

module insn_execute (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      ins_valid_i,
  input  bexlite_isa_pkg::opcode_t  opcode_i,
  input  bexlite_isa_pkg::reg_idx_t rd_i,
  input  bexlite_isa_pkg::reg_idx_t ra_i,
  input  bexlite_isa_pkg::reg_idx_t rb_i,
  input  bexlite_isa_pkg::word_t    imm_i,
  output bexlite_isa_pkg::reg_idx_t rd_a_o,
  output bexlite_isa_pkg::reg_idx_t rd_b_o,
  input  bexlite_isa_pkg::word_t    rd_a_data_i,
  input  bexlite_isa_pkg::word_t    rd_b_data_i,
  output logic                      wr_en_o,
  output bexlite_isa_pkg::reg_idx_t wr_idx_o,
  output bexlite_isa_pkg::word_t    wr_data_o,
  output logic                      pc_set_o,
  output bexlite_fetch_pkg::addr_t  pc_target_o,
  output logic                      halted_o
);
  import bexlite_isa_pkg::*;

  logic  active;
  word_t a, b;
  word_t result;
  logic  writes;

  assign active = ins_valid_i && !halted_o;
  assign rd_a_o = ra_i;
  assign rd_b_o = rb_i;

  // forward the write still in flight
  assign a = (wr_en_o && wr_idx_o == ra_i) ? wr_data_o : rd_a_data_i;
  assign b = (wr_en_o && wr_idx_o == rb_i) ? wr_data_o : rd_b_data_i;

  assign pc_set_o    = active && (opcode_i == JMP);
  assign pc_target_o = imm_i;

  always_comb
  begin
    writes = 1'b1;
    result = '0;
    case (opcode_i)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      ADDI:    result = a + imm_i;
      LDI:     result = imm_i;
      default: writes = 1'b0;   // nop, jmp, halt
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_en_o  <= 1'b0;
      halted_o <= 1'b0;
    end
    else
    begin
      wr_en_o <= active && writes;
      if (active && opcode_i == HALT)
        halted_o <= 1'b1;   // sticky
    end
  end

  always_ff @(posedge clk_i)
  begin
    wr_idx_o  <= rd_i;
    wr_data_o <= result;
  end

endmodule

`default_nettype wire

// File: hw/reg_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "bexlite_settings.svh"

module reg_result (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      wr_en_i,
  input  bexlite_isa_pkg::reg_idx_t wr_idx_i,
  input  bexlite_isa_pkg::word_t    wr_data_i,
  input  bexlite_isa_pkg::reg_idx_t rd_a_i,
  input  bexlite_isa_pkg::reg_idx_t rd_b_i,
  output bexlite_isa_pkg::word_t    rd_a_data_o,
  output bexlite_isa_pkg::word_t    rd_b_data_o,
  output logic                      res_valid_o,
  output bexlite_isa_pkg::reg_idx_t res_reg_o,
  output bexlite_isa_pkg::word_t    res_data_o
);
  import bexlite_isa_pkg::*;

  word_t regs [`NUM_REGS];

  assign rd_a_data_o = regs[rd_a_i];
  assign rd_b_data_o = regs[rd_b_i];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
      res_valid_o <= 1'b0;
    end
    else
    begin
      if (wr_en_i)
        regs[wr_idx_i] <= wr_data_i;
      res_valid_o <= wr_en_i;   // echo of the write
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_reg_o  <= wr_idx_i;
    res_data_o <= wr_data_i;
  end

endmodule

`default_nettype wire

// File: hw/bexlite_core.sv
`timescale 1ns/1ps
`default_nettype none

module bexlite_core (
  input  logic                      clk_i,
  input  logic                      rst_i,
  output logic                      bus_cyc_o,
  output logic                      bus_stb_o,
  output bexlite_fetch_pkg::addr_t  bus_adr_o,
  input  logic                      bus_stall_i,
  input  logic                      bus_ack_i,
  input  bexlite_isa_pkg::word_t    bus_dat_i,
  output logic                      res_valid_o,
  output bexlite_isa_pkg::reg_idx_t res_reg_o,
  output bexlite_isa_pkg::word_t    res_data_o,
  output logic                      halt_o
);
  import bexlite_isa_pkg::*;
  import bexlite_fetch_pkg::*;

  logic [63:0] ir;
  logic        pc_set;
  addr_t       pc_target;
  logic        halted;
  logic        ins_valid;
  opcode_t     opcode;
  reg_idx_t    rd, ra, rb;
  word_t       imm;
  reg_idx_t    rd_a, rd_b;
  word_t       rd_a_data, rd_b_data;
  logic        wr_en;
  reg_idx_t    wr_idx;
  word_t       wr_data;

  assign halt_o = halted;

  ifetch ifetch_i (
    .clk_i (clk_i), .rst_i (rst_i),
    .bus_cyc_o (bus_cyc_o), .bus_stb_o (bus_stb_o), .bus_adr_o (bus_adr_o),
    .bus_stall_i (bus_stall_i), .bus_ack_i (bus_ack_i), .bus_dat_i (bus_dat_i),
    .ir_o (ir), .pc_set_i (pc_set), .pc_target_i (pc_target),
    .halt_i (halted)   // also the fetch stall
  );

  insn_decode insn_decode_i (
    .clk_i (clk_i), .rst_i (rst_i), .ir_i (ir), .flush_i (pc_set),
    .ins_valid_o (ins_valid), .opcode_o (opcode),
    .rd_o (rd), .ra_o (ra), .rb_o (rb), .imm_o (imm)
  );

  insn_execute insn_execute_i (
    .clk_i (clk_i), .rst_i (rst_i),
    .ins_valid_i (ins_valid), .opcode_i (opcode),
    .rd_i (rd), .ra_i (ra), .rb_i (rb), .imm_i (imm),
    .rd_a_o (rd_a), .rd_b_o (rd_b),
    .rd_a_data_i (rd_a_data), .rd_b_data_i (rd_b_data),
    .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_data_o (wr_data),
    .pc_set_o (pc_set), .pc_target_o (pc_target), .halted_o (halted)
  );

  reg_result reg_result_i (
    .clk_i (clk_i), .rst_i (rst_i),
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_data_i (wr_data),
    .rd_a_i (rd_a), .rd_b_i (rd_b),
    .rd_a_data_o (rd_a_data), .rd_b_data_o (rd_b_data),
    .res_valid_o (res_valid_o), .res_reg_o (res_reg_o), .res_data_o (res_data_o)
  );

endmodule

`default_nettype wire

// File: dv/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
  parameter int          AWIDTH = 8,
  parameter int unsigned SEED   = 32'h1
) (
  input  logic                     clk_i,
  input  logic                     bus_cyc_i,
  input  logic                     bus_stb_i,
  input  bexlite_fetch_pkg::addr_t bus_adr_i,
  output logic                     bus_stall_o,
  output logic                     bus_ack_o,
  output bexlite_isa_pkg::word_t   bus_dat_o
);
  import bexlite_isa_pkg::*;
  import bexlite_fetch_pkg::*;

  localparam int WORDS = 1 << AWIDTH;

  word_t mem [WORDS];

  initial
  begin
    logic        take;
    addr_t       adr;
    int unsigned seed_ret;
    seed_ret = $urandom(SEED);
    for (int i = 0; i < WORDS; i++)
      mem[i] = 32'ha5a50000 ^ 32'(i << 2);   // marks the byte address
    bus_stall_o = 1'b0;
    bus_ack_o   = 1'b0;
    bus_dat_o   = '0;
    forever
    begin
      @(negedge clk_i);
      take = bus_cyc_i && bus_stb_i && !bus_stall_o;   // accepted at the next edge
      adr  = bus_adr_i;
      @(posedge clk_i);
      #1;
      bus_ack_o   = take;
      bus_dat_o   = take ? mem[adr[AWIDTH+1:2]] : '0;
      bus_stall_o = ($urandom % 4) == 0;   // roughly one cycle in four
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_bexlite_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "bexlite_settings.svh"

module tb_bexlite_core;
  import bexlite_isa_pkg::*;
  import bexlite_fetch_pkg::*;

  localparam string CASES_FILE = "dv/bexlite_cases.txt";
  localparam int    MEM_AWIDTH = 8;
  localparam int    IDLE_WATCH = 32;   // quiet cycles required after halt

  logic     clk_i;
  logic     rst_i;
  logic     bus_cyc;
  logic     bus_stb;
  addr_t    bus_adr;
  logic     bus_stall;
  logic     bus_ack;
  word_t    bus_dat;
  logic     res_valid;
  reg_idx_t res_reg;
  word_t    res_data;
  logic     halt;

  addr_t    prog_addr_q [$];
  word_t    prog_data_q [$];
  reg_idx_t exp_reg_q [$];
  word_t    exp_data_q [$];

  int mismatch_errors = 0;
  int write_errors    = 0;
  int bus_errors      = 0;
  int setup_errors    = 0;
  int timeout_errors  = 0;
  int cycle_limit     = 0;
  int cycle_count     = 0;
  bit halt_seen       = 1'b0;

  bexlite_core bexlite_core_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_cyc_o   (bus_cyc),
    .bus_stb_o   (bus_stb),
    .bus_adr_o   (bus_adr),
    .bus_stall_i (bus_stall),
    .bus_ack_i   (bus_ack),
    .bus_dat_i   (bus_dat),
    .res_valid_o (res_valid),
    .res_reg_o   (res_reg),
    .res_data_o  (res_data),
    .halt_o      (halt)
  );

  wb_mem_model #(.AWIDTH(MEM_AWIDTH), .SEED(32'hb1d4a30d)) mem_i (
    .clk_i       (clk_i),
    .bus_cyc_i   (bus_cyc),
    .bus_stb_i   (bus_stb),
    .bus_adr_i   (bus_adr),
    .bus_stall_o (bus_stall),
    .bus_ack_o   (bus_ack),
    .bus_dat_o   (bus_dat)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_low(input string name, input logic got);
    if (got !== 1'b0)
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: %s got %b, expected 0", $time, name, got);
    end
  endtask

  task automatic read_cases(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] d;
    bit          done;
    ok   = 1'b0;
    done = 1'b0;
    fd   = $fopen(CASES_FILE, "r");
    if (fd == 0)
    begin
      setup_errors++;
      $display("Could not open the cases file %s", CASES_FILE);
    end
    else
    begin
      while (!done && $fgets(line, fd) > 0)
      begin
        tag = line.getc(0);
        if (tag == "E")
          done = 1'b1;
        else if (tag == "M" || tag == "W")
        begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
          if (n != 2)
          begin
            setup_errors++;
            $display("Unreadable line in the cases file: %s", line);
          end
          else if (tag == "M")
          begin
            prog_addr_q.push_back(a);
            prog_data_q.push_back(d);
          end
          else
          begin
            exp_reg_q.push_back(reg_idx_t'(a));
            exp_data_q.push_back(d);
          end
        end
      end
      $fclose(fd);
      if (!done)
      begin
        setup_errors++;
        $display("The cases file has no end marker");
      end
      ok = done && (setup_errors == 0);
    end
  endtask

  task automatic load_program();
    addr_t a;
    for (int i = 0; i < prog_addr_q.size(); i++)
    begin
      a = prog_addr_q[i];
      if ((a >> (MEM_AWIDTH + 2)) != 0)
      begin
        setup_errors++;
        $display("Program address %h lies outside the memory model", a);
      end
      else
        mem_i.mem[a[MEM_AWIDTH+1:2]] = prog_data_q[i];
    end
  endtask

  task automatic take_write();
    reg_idx_t r;
    word_t    d;
    if (exp_reg_q.size() == 0)
    begin
      write_errors++;
      $display("Unexpected write at %0t ns: r%0d <= %h after the last expected write",
               $time, res_reg, res_data);
    end
    else
    begin
      r = exp_reg_q.pop_front();
      d = exp_data_q.pop_front();
      check_reg("res_reg_o", res_reg, r);
      check_data("res_data_o", res_data, d);
    end
  endtask

  task automatic report_and_finish();
    int total;
    total = mismatch_errors + write_errors + bus_errors + setup_errors + timeout_errors;
    $display("errors: mismatch %0d, writes %0d, bus %0d, setup %0d, timeout %0d",
             mismatch_errors, write_errors, bus_errors, setup_errors, timeout_errors);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  // writes are compared mid-cycle
  always @(negedge clk_i)
  begin
    if (!rst_i && res_valid)
    begin
      if (halt_seen)
      begin
        write_errors++;
        $display("A write appeared at %0t ns after halt: r%0d <= %h",
                 $time, res_reg, res_data);
      end
      else
        take_write();
    end
    if (!rst_i && halt && !halt_seen)
    begin
      halt_seen = 1'b1;   // last write may share the halt edge
      if (exp_reg_q.size() != 0)
      begin
        write_errors += exp_reg_q.size();
        $display("%0d expected writes never appeared before halt", exp_reg_q.size());
      end
    end
  end

  initial
  begin
    bit cases_ok;
    int cyc_high;
    rst_i    = 1'b1;
    cyc_high = 0;
    read_cases(cases_ok);
    cycle_limit = 200 * prog_addr_q.size() + 500;
    if (cases_ok)
    begin
      #1;
      load_program();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      expect_low("bus_cyc_o", bus_cyc);
      expect_low("bus_stb_o", bus_stb);
      expect_low("res_valid_o", res_valid);
      expect_low("halt_o", halt);
      check_addr("bus_adr_o", bus_adr, `START_ADDR);
      @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      while (!halt)
        @(negedge clk_i);
      $display("halt_o seen at %0t ns", $time);
      while (bus_cyc)
        @(negedge clk_i);   // outstanding acks drain first
      repeat (IDLE_WATCH)
      begin
        @(negedge clk_i);
        if (bus_cyc)
          cyc_high++;
      end
      if (cyc_high != 0)
      begin
        bus_errors++;
        $display("The bus cycle started again after halt, high for %0d cycles", cyc_high);
      end
    end
    report_and_finish();
  end

  initial
  begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    timeout_errors++;
    $display("Timeout: the run did not end within %0d cycles", cycle_limit);
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/bexlite_isa_pkg.sv
hw/bexlite_fetch_pkg.sv
hw/fetch_fifo.sv
hw/ifetch.sv
hw/insn_decode.sv
hw/insn_execute.sv
hw/reg_result.sv
hw/bexlite_core.sv
dv/wb_mem_model.sv
dv/tb_bexlite_core.sv

// File: run.sh
#!/usr/bin/env bash
# builds the bexlite testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  -f list.f --top-module tb_bexlite_core -Mdir obj_dir -o tb_bexlite_core \
  && ./obj_dir/tb_bexlite_core 2>&1 | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -q "SIMULATION FAILED" sim.log \
  && { echo "test failed, see sim.log"; exit 1; } \
  || { echo "test passed"; exit 0; }

// File: dv/bexlite_cases.txt
# M <byte address> <word>: program memory, hex
# W <register> <value>: expected write-backs in order, hex; E ends the file
M 00000000 000a002c addi r1 r0 5
M 00000004 0006024c addi r2 r1 3
M 00000008 00004262 add r3 r1 r2
M 0000000c 0000008f ldi r4 first half, straddles a burst
M 00000010 12345678 ldi r4 immediate
M 00000014 000068a4 sub r5 r4 r3
M 00000018 00000011 jmp first half
M 0000001c 00000030 jmp target
M 00000020 0ffe00cc addi r6 r0 7ff, skipped by jmp
M 00000024 00002222 add r1 r1 r1, skipped by jmp
M 00000030 00002aca xor r6 r5 r1
M 00000034 00008ce6 and r7 r6 r4
M 00000038 0000010f ldi r8 first half
M 0000003c cafef00d ldi r8 immediate
M 00000040 0000f128 or r9 r8 r7
M 00000044 00000012 halt
M 00000048 0002014c addi r10 r0 1, after halt
W 1 00000005
W 2 00000008
W 3 0000000d
W 4 12345678
W 5 1234566b
W 6 1234566e
W 7 12345668
W 8 cafef00d
W 9 dafef66d
E
